//--- src/prev_frame_pkg.sv
/*
 * Shared widths and types for the previous-frame pipeline.
 * FRAME_PIXELS set at the top level must not exceed 2**ADDR_W.
 */
package prev_frame_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int PIX_W  = 8;
    localparam int USER_W = 1;
    localparam int ADDR_W = 10;    // frame store address

    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [USER_W-1:0] user_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // ------------------------------
    // side-band of each pixel
    // ------------------------------
    typedef struct packed {
        logic  line_first;
        logic  line_last;
        logic  pixel_first;
        logic  pixel_last;
        logic  de;
        user_t user;
    } img_flags_t;

    // frame permission FSM
    typedef enum logic [1:0] {
        ST_IDLE,    // disabled, frame store untouched
        ST_FILL,    // first enabled frame, store only
        ST_RUN      // read previous frame and store current
    } frame_state_t;

endpackage

//--- src/frame_state_ctl.sv
/*
 * Frame-start FSM. enable_i is only looked at on the frame-start pixel,
 * so read/write permissions never change in the middle of a frame.
 */
`timescale 1ns/10ps

module frame_state_ctl import prev_frame_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cke_i,
    input  logic       enable_i,
    input  img_flags_t s_flags_i,
    input  logic       s_valid_i,
    output logic       restart_o,
    output logic       read_ok_o,
    output logic       write_ok_o
);

    frame_state_t state;

    // first pixel of first line starts a frame
    assign restart_o = cke_i & s_valid_i & s_flags_i.line_first & s_flags_i.pixel_first;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            read_ok_o  <= 1'b0;
            write_ok_o <= 1'b0;
        end else if (restart_o) begin
            if (!enable_i) begin
                state      <= ST_IDLE;
                read_ok_o  <= 1'b0;
                write_ok_o <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        state      <= ST_FILL;    // nothing stored yet
                        read_ok_o  <= 1'b0;
                        write_ok_o <= 1'b1;
                    end
                    default: begin
                        state      <= ST_RUN;
                        read_ok_o  <= 1'b1;
                        write_ok_o <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

//--- src/pixel_addr_counter.sv
/*
 * Frame store address of each pixel, valid alongside pipeline stage 0.
 * Saturates at FRAME_PIXELS; in_range_o is low from there on.
 */
`timescale 1ns/10ps

module pixel_addr_counter import prev_frame_pkg::*; #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cke_i,
    input  logic       restart_i,
    input  img_flags_t s_flags_i,
    input  logic       s_valid_i,
    output addr_t      addr_o,
    output logic       in_range_o
);

    localparam logic [ADDR_W:0] CNT_END = (ADDR_W + 1)'(FRAME_PIXELS);
    localparam logic [ADDR_W:0] CNT_ONE = {{ADDR_W{1'b0}}, 1'b1};

    logic [ADDR_W:0] cnt_q;    // one extra bit so the end value fits
    logic            step_q;   // last pixel was a valid de pixel

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q  <= '0;
            step_q <= 1'b0;
        end else if (cke_i) begin
            if (restart_i) begin
                cnt_q <= '0;
            end else if (step_q && cnt_q < CNT_END) begin
                cnt_q <= cnt_q + CNT_ONE;
            end
            step_q <= s_valid_i & s_flags_i.de;
        end
    end

    assign addr_o     = cnt_q[ADDR_W-1:0];
    assign in_range_o = (cnt_q < CNT_END);

endmodule

//--- src/frame_store_ram.sv
/*
 * Single-clock frame store, FRAME_PIXELS words deep, no reset.
 * Registered read, 1 cycle; holds its output while rd_hold_i is high.
 */
`timescale 1ns/10ps

module frame_store_ram import prev_frame_pkg::*; #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic  clk,
    input  addr_t rd_addr_i,
    input  logic  wr_en_i,
    input  addr_t wr_addr_i,
    input  pix_t  wr_data_i,
    input  logic  rd_hold_i,
    output pix_t  rd_data_o
);

    localparam int IDX_W = (FRAME_PIXELS > 1) ? $clog2(FRAME_PIXELS) : 1;

    pix_t             mem [FRAME_PIXELS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // upper address bits only matter once the counter saturates
    assign rd_idx = rd_addr_i[IDX_W-1:0];
    assign wr_idx = wr_addr_i[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rd_hold_i) begin
            rd_data_o <= mem[rd_idx];    // stall keeps read data
        end
    end

endmodule

//--- src/prev_pixel_pipe.sv
/*
 * Pixel pipeline, 2 cycles from s_* to m_*, stalled by a low cke_i.
 * Read issued from stage 0, stored pixel written back from stage 1.
 */
`timescale 1ns/10ps

module prev_pixel_pipe import prev_frame_pkg::*; #(
    parameter pix_t DEFAULT_DATA = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cke_i,
    input  img_flags_t s_flags_i,
    input  pix_t       s_data_i,
    input  logic       s_valid_i,
    input  addr_t      addr_i,
    input  logic       in_range_i,
    input  logic       read_ok_i,
    input  logic       write_ok_i,
    input  pix_t       rd_data_i,
    output addr_t      rd_addr_o,
    output logic       rd_hold_o,
    output logic       wr_en_o,
    output addr_t      wr_addr_o,
    output pix_t       wr_data_o,
    output img_flags_t m_flags_o,
    output pix_t       m_data_o,
    output logic       m_prev_de_o,
    output pix_t       m_prev_data_o,
    output logic       m_valid_o
);

    img_flags_t st0_flags;
    pix_t       st0_data;
    logic       st0_valid;

    img_flags_t st1_flags;
    pix_t       st1_data;
    logic       st1_valid;
    addr_t      st1_addr;
    logic       st1_prev_de;   // stored pixel usable
    logic       st1_store;     // write this pixel back

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid   <= 1'b0;
            st1_valid   <= 1'b0;
            st1_prev_de <= 1'b0;
            st1_store   <= 1'b0;
        end else if (cke_i) begin
            st0_valid   <= s_valid_i;
            st1_valid   <= st0_valid;
            st1_prev_de <= st0_valid & st0_flags.de & read_ok_i & in_range_i;
            st1_store   <= st0_valid & st0_flags.de & write_ok_i & in_range_i;
        end
    end

    // ------------------------------
    // payload
    // ------------------------------
    always_ff @(posedge clk) begin
        if (cke_i) begin
            st0_flags <= s_flags_i;
            st0_data  <= s_data_i;
            st1_flags <= st0_flags;
            st1_data  <= st0_data;
            st1_addr  <= addr_i;
        end
    end

    assign rd_addr_o = addr_i;    // data lands with stage 1
    assign rd_hold_o = ~cke_i;

    assign wr_en_o   = cke_i & st1_store;
    assign wr_addr_o = st1_addr;
    assign wr_data_o = st1_data;

    // stage 2, output select
    assign m_flags_o     = st1_flags;
    assign m_data_o      = st1_data;
    assign m_valid_o     = st1_valid;
    assign m_prev_de_o   = st1_prev_de;
    assign m_prev_data_o = st1_prev_de ? rd_data_i : DEFAULT_DATA;

endmodule

//--- src/prev_frame_top.sv
/*
 * Previous-frame pixel merge with an on-chip frame store.
 * No back-pressure; the source pauses only with s_valid_i or cke_i.
 * Outputs follow inputs by 2 cke-high cycles.
 */
`timescale 1ns/10ps

module prev_frame_top import prev_frame_pkg::*; #(
    parameter int   FRAME_PIXELS = 64,
    parameter pix_t DEFAULT_DATA = 8'h00
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cke_i,
    input  logic       enable_i,
    input  img_flags_t s_flags_i,
    input  pix_t       s_data_i,
    input  logic       s_valid_i,
    output img_flags_t m_flags_o,
    output pix_t       m_data_o,
    output logic       m_prev_de_o,
    output pix_t       m_prev_data_o,
    output logic       m_valid_o
);

    logic  restart;
    logic  read_ok;
    logic  write_ok;
    addr_t addr;
    logic  in_range;
    addr_t rd_addr;
    logic  rd_hold;
    pix_t  rd_data;
    logic  wr_en;
    addr_t wr_addr;
    pix_t  wr_data;

    frame_state_ctl u_frame_state_ctl (
        .clk        (clk),
        .reset      (reset),
        .cke_i      (cke_i),
        .enable_i   (enable_i),
        .s_flags_i  (s_flags_i),
        .s_valid_i  (s_valid_i),
        .restart_o  (restart),
        .read_ok_o  (read_ok),
        .write_ok_o (write_ok)
    );

    pixel_addr_counter #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) u_pixel_addr_counter (
        .clk        (clk),
        .reset      (reset),
        .cke_i      (cke_i),
        .restart_i  (restart),
        .s_flags_i  (s_flags_i),
        .s_valid_i  (s_valid_i),
        .addr_o     (addr),
        .in_range_o (in_range)
    );

    frame_store_ram #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) u_frame_store_ram (
        .clk       (clk),
        .rd_addr_i (rd_addr),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_hold_i (rd_hold),
        .rd_data_o (rd_data)
    );

    prev_pixel_pipe #(
        .DEFAULT_DATA (DEFAULT_DATA)
    ) u_prev_pixel_pipe (
        .clk           (clk),
        .reset         (reset),
        .cke_i         (cke_i),
        .s_flags_i     (s_flags_i),
        .s_data_i      (s_data_i),
        .s_valid_i     (s_valid_i),
        .addr_i        (addr),
        .in_range_i    (in_range),
        .read_ok_i     (read_ok),
        .write_ok_i    (write_ok),
        .rd_data_i     (rd_data),
        .rd_addr_o     (rd_addr),
        .rd_hold_o     (rd_hold),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data),
        .m_flags_o     (m_flags_o),
        .m_data_o      (m_data_o),
        .m_prev_de_o   (m_prev_de_o),
        .m_prev_data_o (m_prev_data_o),
        .m_valid_o     (m_valid_o)
    );

endmodule

//--- sim/prev_frame_props.sv
/*
 * Concurrent checks on the prev_frame_top outputs, attached by bind.
 */
`timescale 1ns/10ps

module prev_frame_props import prev_frame_pkg::*; #(
    parameter pix_t DEFAULT_DATA = 8'h00
) (
    input logic       clk,
    input logic       reset,
    input logic       cke_i,
    input logic       s_valid_i,
    input logic       m_valid_i,
    input logic       m_prev_de_i,
    input img_flags_t m_flags_i,
    input pix_t       m_prev_data_i
);

    logic [1:0] valid_hist;    // s_valid_i over the last 2 cke cycles
    int         assert_fails = 0;    // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_hist <= 2'b00;
        end else if (cke_i) begin
            valid_hist <= {valid_hist[0], s_valid_i};
        end
    end

    valid_delay: assert property (@(posedge clk) disable iff (reset)
        m_valid_i == valid_hist[1])
        else begin
            assert_fails++;
            $error("m_valid_o does not follow s_valid_i by 2 cke cycles");
        end

    prev_de_qualified: assert property (@(posedge clk) disable iff (reset)
        m_prev_de_i |-> (m_valid_i && m_flags_i.de))
        else begin
            assert_fails++;
            $error("m_prev_de_o high without a valid de pixel");
        end

    default_when_idle: assert property (@(posedge clk) disable iff (reset)
        !m_prev_de_i |-> (m_prev_data_i == DEFAULT_DATA))
        else begin
            assert_fails++;
            $error("m_prev_data_o differs from DEFAULT_DATA with m_prev_de_o low");
        end

endmodule

//--- sim/tb_prev_frame.sv
/*
 * Testbench for prev_frame_top. Frames have 8 de pixels and one blanking
 * pixel per line. Expected values come from a frame model in this file.
 */
`timescale 1ns/10ps

module tb_prev_frame import prev_frame_pkg::*; ();

    localparam int   FRAME_PIXELS = 64;
    localparam int   IDX_W        = $clog2(FRAME_PIXELS);
    localparam int   LINES        = 8;
    localparam int   LINE_PIX     = 8;
    localparam pix_t DEFAULT_DATA = 8'h3c;

    typedef struct packed {
        img_flags_t flags;
        pix_t       data;
        logic       prev_de;
        pix_t       prev_data;
    } expect_t;

    logic       clk;
    logic       reset;
    logic       cke_i;
    logic       enable_i;
    img_flags_t s_flags_i;
    pix_t       s_data_i;
    logic       s_valid_i;
    img_flags_t m_flags_o;
    pix_t       m_data_o;
    logic       m_prev_de_o;
    pix_t       m_prev_data_o;
    logic       m_valid_o;

    integer  seed = 32'hcda1c6e7;
    expect_t expect_q[$];
    int      errors;
    int      test_base;
    int      test_no;
    int      tests_failed;
    int      hits;          // prev_de outputs seen in the current test
    logic    stall_on;

    // frame model
    pix_t         model_mem [FRAME_PIXELS];
    frame_state_t model_state;
    logic         model_read;
    logic         model_write;
    int           model_cnt;

    prev_frame_top #(
        .FRAME_PIXELS (FRAME_PIXELS),
        .DEFAULT_DATA (DEFAULT_DATA)
    ) u_prev_frame_top (
        .clk           (clk),
        .reset         (reset),
        .cke_i         (cke_i),
        .enable_i      (enable_i),
        .s_flags_i     (s_flags_i),
        .s_data_i      (s_data_i),
        .s_valid_i     (s_valid_i),
        .m_flags_o     (m_flags_o),
        .m_data_o      (m_data_o),
        .m_prev_de_o   (m_prev_de_o),
        .m_prev_data_o (m_prev_data_o),
        .m_valid_o     (m_valid_o)
    );

    // names below resolve inside prev_frame_top
    bind prev_frame_top prev_frame_props #(
        .DEFAULT_DATA (DEFAULT_DATA)
    ) u_prev_frame_props (
        .clk           (clk),
        .reset         (reset),
        .cke_i         (cke_i),
        .s_valid_i     (s_valid_i),
        .m_valid_i     (m_valid_o),
        .m_prev_de_i   (m_prev_de_o),
        .m_flags_i     (m_flags_o),
        .m_prev_data_i (m_prev_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic expect_t predict_pixel(img_flags_t f, pix_t d, logic en);
        expect_t e;
        logic    hit;
        if (f.line_first && f.pixel_first) begin
            model_cnt = 0;
            if (!en) begin
                model_state = ST_IDLE;
                model_read  = 1'b0;
                model_write = 1'b0;
            end else if (model_state == ST_IDLE) begin
                model_state = ST_FILL;    // nothing stored yet
                model_read  = 1'b0;
                model_write = 1'b1;
            end else begin
                model_state = ST_RUN;
                model_read  = 1'b1;
                model_write = 1'b1;
            end
        end
        hit         = f.de && model_read && (model_cnt < FRAME_PIXELS);
        e.flags     = f;
        e.data      = d;
        e.prev_de   = hit;
        e.prev_data = hit ? model_mem[model_cnt[IDX_W-1:0]] : DEFAULT_DATA;
        if (f.de && model_write && (model_cnt < FRAME_PIXELS)) begin
            model_mem[model_cnt[IDX_W-1:0]] = d;    // read above sees the old word
        end
        if (f.de) begin
            model_cnt++;
        end
        return e;
    endfunction

    task automatic report_value(string name, logic [7:0] got, logic [7:0] exp);
        $display("ERR %s at %0t: got %h expected %h", name, $time, got, exp);
        errors++;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic send_pixel(img_flags_t f, pix_t d);
        integer r;
        logic   sent;
        int     tries;
        sent = 1'b0;
        for (tries = 0; tries < 16 && !sent; tries++) begin
            @(negedge clk);
            r = $random(seed);
            if (stall_on && r[17:16] == 2'b00 && tries != 15) begin
                cke_i     = 1'b0;    // junk that must be ignored
                s_valid_i = 1'b1;
                s_flags_i = img_flags_t'(r[13:8]);
                s_data_i  = r[7:0];
            end else if (r[20:18] == 3'b000 && tries != 15) begin
                cke_i     = 1'b1;
                s_valid_i = 1'b0;
                s_flags_i = img_flags_t'(r[13:8]);
                s_data_i  = r[7:0];
            end else begin
                cke_i     = 1'b1;
                s_valid_i = 1'b1;
                s_flags_i = f;
                s_data_i  = d;
                expect_q.push_back(predict_pixel(f, d, enable_i));
                sent = 1'b1;
            end
        end
    endtask

    task automatic send_frame(int lines, logic en);
        img_flags_t f;
        integer     r;
        logic       de;
        enable_i = en;
        for (int y = 0; y < lines; y++) begin
            for (int x = 0; x <= LINE_PIX; x++) begin
                de            = (x < LINE_PIX);    // last slot is blanking
                f.line_first  = de && (y == 0);
                f.line_last   = de && (y == lines - 1);
                f.pixel_first = (x == 0);
                f.pixel_last  = (x == LINE_PIX - 1);
                f.de          = de;
                f.user        = (y == 0 && x == 0);
                r = $random(seed);
                send_pixel(f, r[7:0]);
            end
        end
    endtask

    task automatic drain_pipe();
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < 100) begin
            @(negedge clk);
            cke_i     = 1'b1;
            s_valid_i = 1'b0;
            n++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout: %0d output pixels never appeared", expect_q.size());
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic finish_test(string name, int exp_hits);
        drain_pipe();
        test_no++;
        if (hits != exp_hits) begin
            $display("ERR prev_de hit count: got %h expected %h", hits, exp_hits);
            errors++;
        end
        if (errors == test_base) begin
            $display("test %0d %s: ok, %0d prev_de hits", test_no, name, hits);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_no, name, errors - test_base);
        end
        test_base = errors;
        hits      = 0;
    endtask

    // ------------------------------
    // output compare
    // ------------------------------
    initial begin : compare_outputs
        logic        was_cke;
        expect_t     e;
        logic [23:0] now_out;
        logic [23:0] last_out;
        last_out = '0;
        forever begin
            @(posedge clk);
            was_cke = cke_i;
            @(negedge clk);
            now_out = {m_flags_o, m_data_o, m_prev_de_o, m_prev_data_o, m_valid_o};
            if (!reset) begin
                if (!was_cke) begin
                    if (now_out != last_out) begin
                        $display("ERR outputs during stall: got %h expected %h",
                                 now_out, last_out);
                        errors++;
                    end
                end else if (m_valid_o) begin
                    if (expect_q.size() == 0) begin
                        $display("output pixel at %0t has no matching input pixel", $time);
                        errors++;
                    end else begin
                        e = expect_q.pop_front();
                        if (m_flags_o != e.flags)
                            report_value("m_flags_o", {2'b00, m_flags_o}, {2'b00, e.flags});
                        if (m_data_o != e.data)
                            report_value("m_data_o", m_data_o, e.data);
                        if (m_prev_de_o != e.prev_de)
                            report_value("m_prev_de_o", {7'b0, m_prev_de_o}, {7'b0, e.prev_de});
                        if (m_prev_data_o != e.prev_data)
                            report_value("m_prev_data_o", m_prev_data_o, e.prev_data);
                        if (m_prev_de_o)
                            hits++;
                    end
                end
            end
            last_out = now_out;
        end
    end

    initial begin
        reset        = 1'b1;
        cke_i        = 1'b1;
        enable_i     = 1'b0;
        s_flags_i    = '0;
        s_data_i     = '0;
        s_valid_i    = 1'b0;
        stall_on     = 1'b0;
        errors       = 0;
        test_base    = 0;
        test_no      = 0;
        tests_failed = 0;
        hits         = 0;
        model_state  = ST_IDLE;
        model_read   = 1'b0;
        model_write  = 1'b0;
        model_cnt    = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        send_frame(LINES, 1'b0);
        finish_test("pass-through with valid gaps", 0);
        send_frame(LINES, 1'b1);
        finish_test("first frame after enable", 0);
        send_frame(LINES, 1'b1);
        send_frame(LINES, 1'b1);
        finish_test("second and third frames", 2 * FRAME_PIXELS);
        send_frame(LINES, 1'b0);
        send_frame(LINES, 1'b1);
        send_frame(LINES, 1'b1);
        finish_test("enable dropped for one frame", FRAME_PIXELS);
        stall_on = 1'b1;
        send_frame(LINES, 1'b1);
        send_frame(LINES, 1'b1);
        stall_on = 1'b0;
        finish_test("cke stalls", 2 * FRAME_PIXELS);
        send_frame(LINES + 2, 1'b1);    // 80 de pixels
        send_frame(LINES + 2, 1'b1);
        send_frame(LINES, 1'b1);
        finish_test("oversized frames", 3 * FRAME_PIXELS);

        if (u_prev_frame_top.u_prev_frame_props.assert_fails != 0) begin
            $display("%0d concurrent assertion failures",
                     u_prev_frame_top.u_prev_frame_props.assert_fails);
            errors += u_prev_frame_top.u_prev_frame_props.assert_fails;
        end
        $display("tests %0d, failed %0d, errors %0d", test_no, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/prev_frame_pkg.sv
src/frame_state_ctl.sv
src/pixel_addr_counter.sv
src/frame_store_ram.sv
src/prev_pixel_pipe.sv
src/prev_frame_top.sv
sim/prev_frame_props.sv
sim/tb_prev_frame.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_prev_frame
SEED_FLAGS ?= +verilator+seed+1
VFLAGS     ?= --binary --assert -j 0
BUILD_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED_FLAGS VFLAGS BUILD_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f vlog.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
